// ==== logic/txd_pkg.sv ====
package txd_pkg;

	// Descriptor geometry
	localparam int desc_bytes = 16;
	localparam int desc_shift = 4;
	localparam int local_slots = 16;
	localparam int status_byte_offset = 12;

	// Head/current/tail recompute depth
	localparam int ptr_calc_cycles = 3;

	typedef logic [63:0] host_addr_t;
	typedef logic [15:0] local_addr_t;
	typedef logic [15:0] ring_idx_t;
	typedef logic [12:0] ring_len_t;
	typedef logic [3:0] slot_idx_t;
	typedef logic [4:0] slot_cnt_t;
	typedef logic [15:0] dma_len_t;

	// Ring length counts groups of eight descriptors
	typedef struct packed {
		logic en;
		host_addr_t base;
		ring_len_t len;
	} ring_cfg_t;

	typedef struct packed {
		host_addr_t host_addr;
		local_addr_t local_addr;
		dma_len_t len;
	} dma_cmd_t;

	typedef struct packed {
		logic ide;
		logic rs;
	} desc_flags_t;

	typedef struct packed {
		desc_flags_t flags;
		local_addr_t addr;
	} teng_rsp_t;

	typedef enum logic [3:0] {
		hs_idle, hs_ready, hs_wb_cmd, hs_wb_wait, hs_retire,
		hs_size, hs_fetch_cmd, hs_fetch_wait, hs_accept, hs_settle
	} host_seq_state_t;

	typedef enum logic [2:0] {
		ds_idle, ds_ready, ds_cmd, ds_launch, ds_wait, ds_complete
	} dispatch_state_t;

endpackage

// ==== logic/txd_ring_pointers.sv ====
`timescale 1ns/1ps

module txd_ring_pointers (
	input logic aclk,
	input logic aresetn,
	input txd_pkg::ring_cfg_t ring_cfg,
	input txd_pkg::ring_idx_t tdh,
	input logic tdh_set,
	input txd_pkg::ring_idx_t tdt,
	input logic tdt_set,
	input logic fetch_advance,
	input txd_pkg::slot_cnt_t fetch_count,
	input logic retire_advance,
	output txd_pkg::ring_idx_t head_idx,
	output txd_pkg::ring_idx_t cur_idx,
	output txd_pkg::ring_idx_t fresh_count,
	output txd_pkg::ring_idx_t limit_count,
	output logic ptr_busy,
	output logic txqe_req
);

	localparam int last_stage = txd_pkg::ptr_calc_cycles - 2;

	logic [last_stage:0] calc_stage;
	logic recalc;
	txd_pkg::ring_idx_t ring_size;

	// Stage 0 holds the unwrapped sums
	logic [16:0] head_n0;
	logic [16:0] cur_n0;
	logic [16:0] tail_n0;

	// Stage 1 holds them wrapped into the ring
	txd_pkg::ring_idx_t head_n1;
	txd_pkg::ring_idx_t cur_n1;
	txd_pkg::ring_idx_t tail_n1;

	logic [16:0] fresh_sum;
	logic [16:0] pending_sum;
	txd_pkg::ring_idx_t fresh_next;
	txd_pkg::ring_idx_t pending_next;

	function automatic txd_pkg::ring_idx_t wrap(input logic [16:0] value,
			input txd_pkg::ring_idx_t size);
		if (value >= {1'b0, size})
			return txd_pkg::ring_idx_t'(value - {1'b0, size});
		return txd_pkg::ring_idx_t'(value);
	endfunction

	assign ring_size = {ring_cfg.len, 3'b000};
	assign recalc = tdh_set | tdt_set | fetch_advance | retire_advance;
	assign ptr_busy = |calc_stage;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			calc_stage <= '0;
		else
			calc_stage <= {calc_stage[last_stage-1:0], recalc};
	end

	// Unchanged pointers keep their last value so overlapping events agree
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			head_n0 <= '0;
			cur_n0 <= '0;
			tail_n0 <= '0;
		end else begin
			if (tdh_set)
				head_n0 <= {1'b0, tdh};
			else if (retire_advance)
				head_n0 <= {1'b0, head_idx} + 17'd1;
			if (tdh_set)
				cur_n0 <= {1'b0, tdh};
			else if (fetch_advance)
				cur_n0 <= {1'b0, cur_idx} + 17'(fetch_count);
			if (tdt_set)
				tail_n0 <= {1'b0, tdt};
		end
	end

	always_ff @(posedge aclk) begin
		if (calc_stage[0]) begin
			head_n1 <= wrap(head_n0, ring_size);
			cur_n1 <= wrap(cur_n0, ring_size);
			tail_n1 <= wrap(tail_n0, ring_size);
		end
	end

	// Distances around the ring from the wrapped pointers
	assign fresh_sum = {1'b0, tail_n1} + {1'b0, ring_size} - {1'b0, cur_n1};
	assign pending_sum = {1'b0, tail_n1} + {1'b0, ring_size} - {1'b0, head_n1};
	assign fresh_next = wrap(fresh_sum, ring_size);
	assign pending_next = wrap(pending_sum, ring_size);

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			head_idx <= '0;
			cur_idx <= '0;
			fresh_count <= '0;
			limit_count <= '0;
			txqe_req <= 1'b0;
		end else begin
			txqe_req <= calc_stage[last_stage] && (pending_next == '0);
			if (calc_stage[last_stage]) begin
				head_idx <= head_n1;
				cur_idx <= cur_n1;
				fresh_count <= fresh_next;
				limit_count <= ring_size - cur_n1;
			end
		end
	end

	a_ptr_in_ring: assert property (@(posedge aclk) disable iff (!aresetn)
		calc_stage[last_stage] |=> (head_idx < ring_size) && (cur_idx < ring_size));

endmodule

// ==== logic/txd_local_store.sv ====
`timescale 1ns/1ps

module txd_local_store (
	input logic aclk,
	input logic aresetn,
	input logic fetch_accept,
	input txd_pkg::slot_cnt_t fetch_count,
	input logic launch,
	input logic complete,
	input txd_pkg::desc_flags_t complete_flags,
	input logic retire,
	output txd_pkg::slot_cnt_t in_count,
	output txd_pkg::slot_cnt_t out_count,
	output txd_pkg::slot_idx_t in_head_slot,
	output txd_pkg::slot_idx_t in_tail_slot,
	output txd_pkg::slot_idx_t out_head_slot,
	output txd_pkg::desc_flags_t out_head_flags
);

	// Slot order around the circle: out_head, out_tail, in_head, in_tail
	txd_pkg::slot_idx_t in_head;
	txd_pkg::slot_idx_t in_tail;
	txd_pkg::slot_idx_t out_head;
	txd_pkg::slot_idx_t out_tail;
	txd_pkg::slot_idx_t in_flight;
	logic [5:0] held_total;

	txd_pkg::desc_flags_t flag_mem [txd_pkg::local_slots];

	// In-queue, filled by fetch and drained by launch
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			in_head <= '0;
			in_tail <= '0;
			in_count <= '0;
		end else begin
			if (fetch_accept)
				in_tail <= in_tail + txd_pkg::slot_idx_t'(fetch_count);
			if (launch)
				in_head <= in_head + 4'd1;
			in_count <= in_count + (fetch_accept ? fetch_count : 5'd0)
				- txd_pkg::slot_cnt_t'(launch);
		end
	end

	// Out-queue, filled by completion and drained by retire
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			out_head <= '0;
			out_tail <= '0;
			out_count <= '0;
		end else begin
			if (complete)
				out_tail <= out_tail + 4'd1;
			if (retire)
				out_head <= out_head + 4'd1;
			out_count <= out_count + txd_pkg::slot_cnt_t'(complete)
				- txd_pkg::slot_cnt_t'(retire);
		end
	end

	always_ff @(posedge aclk) begin
		if (complete)
			flag_mem[out_tail] <= complete_flags;
	end

	assign out_head_flags = flag_mem[out_head];

	assign in_head_slot = in_head;
	assign in_tail_slot = in_tail;
	assign out_head_slot = out_head;

	// At most one descriptor sits at the engine between the two queues
	assign in_flight = in_head - out_tail;
	assign held_total = 6'(in_count) + 6'(out_count) + 6'(in_flight);

	a_store_bound: assert property (@(posedge aclk) disable iff (!aresetn)
		held_total <= 6'(txd_pkg::local_slots));

endmodule

// ==== logic/txd_host_sequencer.sv ====
`timescale 1ns/1ps

module txd_host_sequencer (
	input logic aclk,
	input logic aresetn,
	input txd_pkg::ring_cfg_t ring_cfg,
	input txd_pkg::ring_idx_t cur_idx,
	input txd_pkg::ring_idx_t head_idx,
	input txd_pkg::ring_idx_t fresh_count,
	input txd_pkg::ring_idx_t limit_count,
	input logic ptr_busy,
	input txd_pkg::slot_cnt_t in_count,
	input txd_pkg::slot_cnt_t out_count,
	input txd_pkg::slot_idx_t in_tail_slot,
	input txd_pkg::slot_idx_t out_head_slot,
	input txd_pkg::desc_flags_t out_head_flags,
	output txd_pkg::dma_cmd_t idma_cmd,
	output logic idma_valid,
	input logic idma_ready,
	input logic irpt_valid,
	output txd_pkg::dma_cmd_t odma_cmd,
	output logic odma_valid,
	input logic odma_ready,
	input logic orpt_valid,
	output logic fetch_advance,
	output logic fetch_accept,
	output txd_pkg::slot_cnt_t fetch_count,
	output logic retire_advance,
	output logic retire,
	output logic txdw_req
);

	txd_pkg::host_seq_state_t state;
	txd_pkg::host_seq_state_t state_next;
	txd_pkg::slot_cnt_t free_slots;
	txd_pkg::ring_idx_t fetch_min;

	// One slot kept back for the descriptor at the engine
	always_comb begin
		free_slots = txd_pkg::slot_cnt_t'(txd_pkg::local_slots - 1) - in_count - out_count;
		fetch_min = limit_count;
		if (fresh_count < fetch_min)
			fetch_min = fresh_count;
		if (txd_pkg::ring_idx_t'(free_slots) < fetch_min)
			fetch_min = txd_pkg::ring_idx_t'(free_slots);
	end

	always_comb begin
		state_next = state;
		case (state)
			txd_pkg::hs_idle:
				if (ring_cfg.en)
					state_next = txd_pkg::hs_ready;
			txd_pkg::hs_ready: begin
				if (!ring_cfg.en)
					state_next = txd_pkg::hs_idle;
				else if (out_count != '0)
					// Completed descriptors go first
					state_next = out_head_flags.rs ? txd_pkg::hs_wb_cmd : txd_pkg::hs_retire;
				else if (in_count == '0 && fresh_count != '0 && !ptr_busy)
					state_next = txd_pkg::hs_size;
			end
			txd_pkg::hs_wb_cmd:
				if (odma_ready)
					state_next = txd_pkg::hs_wb_wait;
			txd_pkg::hs_wb_wait:
				if (orpt_valid)
					state_next = txd_pkg::hs_retire;
			txd_pkg::hs_retire:
				state_next = txd_pkg::hs_settle;
			txd_pkg::hs_size:
				state_next = (fetch_count != '0) ? txd_pkg::hs_fetch_cmd : txd_pkg::hs_ready;
			txd_pkg::hs_fetch_cmd:
				if (idma_ready)
					state_next = txd_pkg::hs_fetch_wait;
			txd_pkg::hs_fetch_wait:
				if (irpt_valid)
					state_next = txd_pkg::hs_accept;
			txd_pkg::hs_accept:
				state_next = txd_pkg::hs_settle;
			txd_pkg::hs_settle:
				// Pointers must be recomputed before the next decision
				if (!ptr_busy)
					state_next = txd_pkg::hs_ready;
			default:
				state_next = txd_pkg::hs_idle;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			state <= txd_pkg::hs_idle;
		else
			state <= state_next;
	end

	// Command payloads latched as each command is entered
	always_ff @(posedge aclk) begin
		if (state == txd_pkg::hs_ready && state_next == txd_pkg::hs_size)
			fetch_count <= txd_pkg::slot_cnt_t'(fetch_min);
		if (state == txd_pkg::hs_size && state_next == txd_pkg::hs_fetch_cmd) begin
			idma_cmd.host_addr <= ring_cfg.base
				+ (txd_pkg::host_addr_t'(cur_idx) << txd_pkg::desc_shift);
			idma_cmd.local_addr <= txd_pkg::local_addr_t'(in_tail_slot) << txd_pkg::desc_shift;
			idma_cmd.len <= txd_pkg::dma_len_t'(fetch_count)
				* txd_pkg::dma_len_t'(txd_pkg::desc_bytes);
		end
		if (state == txd_pkg::hs_ready && state_next == txd_pkg::hs_wb_cmd) begin
			// Status byte only
			odma_cmd.host_addr <= ring_cfg.base
				+ (txd_pkg::host_addr_t'(head_idx) << txd_pkg::desc_shift)
				+ txd_pkg::host_addr_t'(txd_pkg::status_byte_offset);
			odma_cmd.local_addr <= (txd_pkg::local_addr_t'(out_head_slot) << txd_pkg::desc_shift)
				+ txd_pkg::local_addr_t'(txd_pkg::status_byte_offset);
			odma_cmd.len <= 16'd1;
		end
	end

	assign idma_valid = (state == txd_pkg::hs_fetch_cmd);
	assign odma_valid = (state == txd_pkg::hs_wb_cmd);
	assign fetch_accept = (state == txd_pkg::hs_accept);
	assign fetch_advance = (state == txd_pkg::hs_accept);
	assign retire = (state == txd_pkg::hs_retire);
	assign retire_advance = (state == txd_pkg::hs_retire);

	// Only immediate interrupts are raised
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			txdw_req <= 1'b0;
		else
			txdw_req <= retire && out_head_flags.rs && !out_head_flags.ide;
	end

endmodule

// ==== logic/txd_engine_dispatch.sv ====
`timescale 1ns/1ps

module txd_engine_dispatch (
	input logic aclk,
	input logic aresetn,
	input txd_pkg::ring_cfg_t ring_cfg,
	input txd_pkg::slot_cnt_t in_count,
	input txd_pkg::slot_idx_t in_head_slot,
	output txd_pkg::local_addr_t teng_cmd,
	output logic teng_cmd_valid,
	input logic teng_cmd_ready,
	input txd_pkg::teng_rsp_t teng_rsp,
	input logic teng_rsp_valid,
	output logic teng_rsp_ready,
	output logic launch,
	output logic complete,
	output txd_pkg::desc_flags_t complete_flags
);

	txd_pkg::dispatch_state_t state;
	txd_pkg::dispatch_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			txd_pkg::ds_idle:
				if (ring_cfg.en)
					state_next = txd_pkg::ds_ready;
			txd_pkg::ds_ready:
				if (!ring_cfg.en)
					state_next = txd_pkg::ds_idle;
				else if (in_count != '0)
					state_next = txd_pkg::ds_cmd;
			txd_pkg::ds_cmd:
				if (teng_cmd_ready)
					state_next = txd_pkg::ds_launch;
			txd_pkg::ds_launch:
				state_next = txd_pkg::ds_wait;
			txd_pkg::ds_wait:
				if (teng_rsp_valid)
					state_next = txd_pkg::ds_complete;
			txd_pkg::ds_complete:
				state_next = txd_pkg::ds_ready;
			default:
				state_next = txd_pkg::ds_idle;
		endcase
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			state <= txd_pkg::ds_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge aclk) begin
		if (state == txd_pkg::ds_ready && state_next == txd_pkg::ds_cmd)
			teng_cmd <= txd_pkg::local_addr_t'(in_head_slot) << txd_pkg::desc_shift;
		if (state == txd_pkg::ds_wait && teng_rsp_valid)
			complete_flags <= teng_rsp.flags;
	end

	assign teng_cmd_valid = (state == txd_pkg::ds_cmd);
	assign launch = (state == txd_pkg::ds_launch);
	assign teng_rsp_ready = (state == txd_pkg::ds_wait);
	assign complete = (state == txd_pkg::ds_complete);

	// A stalled command still names the in-queue head, which is popped only on acceptance
	a_cmd_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		teng_cmd_valid && !teng_cmd_ready |=> teng_cmd_valid && $stable(teng_cmd)
			&& teng_cmd == (txd_pkg::local_addr_t'(in_head_slot) << txd_pkg::desc_shift));

	// Engine answers for the descriptor it was handed
	a_rsp_match: assert property (@(posedge aclk) disable iff (!aresetn)
		teng_rsp_valid && teng_rsp_ready |-> teng_rsp.addr == teng_cmd);

endmodule

// ==== logic/tx_desc_ctrl.sv ====
`timescale 1ns/1ps

module tx_desc_ctrl (
	input logic aclk,
	input logic aresetn,
	input txd_pkg::ring_cfg_t ring_cfg,
	input txd_pkg::ring_idx_t tdh,
	input logic tdh_set,
	input txd_pkg::ring_idx_t tdt,
	input logic tdt_set,
	output txd_pkg::ring_idx_t tdh_fb,
	output txd_pkg::dma_cmd_t idma_cmd,
	output logic idma_valid,
	input logic idma_ready,
	input logic irpt_valid,
	output txd_pkg::dma_cmd_t odma_cmd,
	output logic odma_valid,
	input logic odma_ready,
	input logic orpt_valid,
	output txd_pkg::local_addr_t teng_cmd,
	output logic teng_cmd_valid,
	input logic teng_cmd_ready,
	input txd_pkg::teng_rsp_t teng_rsp,
	input logic teng_rsp_valid,
	output logic teng_rsp_ready,
	output logic txdw_req,
	output logic txqe_req
);

	txd_pkg::ring_idx_t cur_idx;
	txd_pkg::ring_idx_t fresh_count;
	txd_pkg::ring_idx_t limit_count;
	logic ptr_busy;
	logic fetch_advance;
	logic fetch_accept;
	txd_pkg::slot_cnt_t fetch_count;
	logic retire_advance;
	logic retire;
	txd_pkg::slot_cnt_t in_count;
	txd_pkg::slot_cnt_t out_count;
	txd_pkg::slot_idx_t in_head_slot;
	txd_pkg::slot_idx_t in_tail_slot;
	txd_pkg::slot_idx_t out_head_slot;
	txd_pkg::desc_flags_t out_head_flags;
	logic launch;
	logic complete;
	txd_pkg::desc_flags_t complete_flags;

	// Head pointer doubles as the software feedback
	txd_ring_pointers u_ptrs (
		.aclk(aclk), .aresetn(aresetn), .ring_cfg(ring_cfg),
		.tdh(tdh), .tdh_set(tdh_set), .tdt(tdt), .tdt_set(tdt_set),
		.fetch_advance(fetch_advance), .fetch_count(fetch_count),
		.retire_advance(retire_advance), .head_idx(tdh_fb), .cur_idx(cur_idx),
		.fresh_count(fresh_count), .limit_count(limit_count),
		.ptr_busy(ptr_busy), .txqe_req(txqe_req)
	);

	txd_local_store u_store (
		.aclk(aclk), .aresetn(aresetn),
		.fetch_accept(fetch_accept), .fetch_count(fetch_count),
		.launch(launch), .complete(complete), .complete_flags(complete_flags),
		.retire(retire), .in_count(in_count), .out_count(out_count),
		.in_head_slot(in_head_slot), .in_tail_slot(in_tail_slot),
		.out_head_slot(out_head_slot), .out_head_flags(out_head_flags)
	);

	txd_host_sequencer u_host_seq (
		.aclk(aclk), .aresetn(aresetn), .ring_cfg(ring_cfg),
		.cur_idx(cur_idx), .head_idx(tdh_fb), .fresh_count(fresh_count),
		.limit_count(limit_count), .ptr_busy(ptr_busy),
		.in_count(in_count), .out_count(out_count),
		.in_tail_slot(in_tail_slot), .out_head_slot(out_head_slot),
		.out_head_flags(out_head_flags),
		.idma_cmd(idma_cmd), .idma_valid(idma_valid), .idma_ready(idma_ready),
		.irpt_valid(irpt_valid),
		.odma_cmd(odma_cmd), .odma_valid(odma_valid), .odma_ready(odma_ready),
		.orpt_valid(orpt_valid),
		.fetch_advance(fetch_advance), .fetch_accept(fetch_accept),
		.fetch_count(fetch_count), .retire_advance(retire_advance),
		.retire(retire), .txdw_req(txdw_req)
	);

	txd_engine_dispatch u_dispatch (
		.aclk(aclk), .aresetn(aresetn), .ring_cfg(ring_cfg),
		.in_count(in_count), .in_head_slot(in_head_slot),
		.teng_cmd(teng_cmd), .teng_cmd_valid(teng_cmd_valid),
		.teng_cmd_ready(teng_cmd_ready),
		.teng_rsp(teng_rsp), .teng_rsp_valid(teng_rsp_valid),
		.teng_rsp_ready(teng_rsp_ready),
		.launch(launch), .complete(complete), .complete_flags(complete_flags)
	);

endmodule

// ==== tests/tb_tx_desc_ctrl.sv ====
`timescale 1ns/1ps

module tb_tx_desc_ctrl;

	localparam txd_pkg::host_addr_t ring_base = 64'h0000_0001_2345_6000;
	localparam txd_pkg::ring_len_t ring_len = 13'd2;
	localparam int ring_desc = 16;
	localparam txd_pkg::ring_idx_t first_tail = 16'd10;
	// Wraps past the ring end for 14 more descriptors
	localparam txd_pkg::ring_idx_t second_tail = 16'd8;
	localparam int total_desc = 24;
	localparam int max_cycles = 4000;

	logic aclk = 1'b0;
	logic aresetn = 1'b0;
	txd_pkg::ring_cfg_t ring_cfg = '0;
	txd_pkg::ring_idx_t tdh = '0;
	logic tdh_set = 1'b0;
	txd_pkg::ring_idx_t tdt = '0;
	logic tdt_set = 1'b0;
	txd_pkg::ring_idx_t tdh_fb;
	txd_pkg::dma_cmd_t idma_cmd;
	logic idma_valid;
	logic idma_ready = 1'b0;
	logic irpt_valid = 1'b0;
	txd_pkg::dma_cmd_t odma_cmd;
	logic odma_valid;
	logic odma_ready = 1'b0;
	logic orpt_valid = 1'b0;
	txd_pkg::local_addr_t teng_cmd;
	logic teng_cmd_valid;
	logic teng_cmd_ready = 1'b0;
	txd_pkg::teng_rsp_t teng_rsp = '0;
	logic teng_rsp_valid = 1'b0;
	logic teng_rsp_ready;
	logic txdw_req;
	logic txqe_req;

	// Scoreboard state with one entry per descriptor in ring order
	bit rs_pattern [0:31];
	int errors = 0;
	int cycle_count = 0;
	txd_pkg::ring_idx_t exp_cur = '0;
	txd_pkg::ring_idx_t exp_head = '0;
	txd_pkg::ring_idx_t head_prev = '0;
	int fetched_total = 0;
	int cmd_count = 0;
	int retired = 0;
	int wb_count = 0;
	int txdw_count = 0;
	logic wb_seen = 1'b0;
	logic qe_after_last = 1'b0;
	int ird_wait = 0;
	int ord_wait = 0;
	int eng_wait = 0;

	logic head_step;
	int fetch_desc;
	logic [5:0] idle_outputs;
	txd_pkg::host_addr_t fetch_addr_exp;
	txd_pkg::local_addr_t fetch_local_exp;
	txd_pkg::local_addr_t slot_addr_exp;
	txd_pkg::host_addr_t wb_addr_exp;
	txd_pkg::local_addr_t wb_local_exp;
	txd_pkg::ring_idx_t head_next_exp;

	assign head_step = (tdh_fb != head_prev);
	assign fetch_desc = int'(idma_cmd.len >> txd_pkg::desc_shift);
	assign idle_outputs = {idma_valid, odma_valid, teng_cmd_valid, teng_rsp_ready,
		txdw_req, txqe_req};
	assign fetch_addr_exp = ring_cfg.base
		+ (txd_pkg::host_addr_t'(exp_cur) << txd_pkg::desc_shift);
	assign fetch_local_exp = txd_pkg::local_addr_t'(fetched_total % txd_pkg::local_slots)
		<< txd_pkg::desc_shift;
	assign slot_addr_exp = txd_pkg::local_addr_t'(cmd_count % txd_pkg::local_slots)
		<< txd_pkg::desc_shift;
	assign wb_addr_exp = ring_cfg.base
		+ (txd_pkg::host_addr_t'(exp_head) << txd_pkg::desc_shift)
		+ txd_pkg::host_addr_t'(txd_pkg::status_byte_offset);
	// Descriptor n sits in local slot n modulo the slot count
	assign wb_local_exp = (txd_pkg::local_addr_t'(retired % txd_pkg::local_slots)
		<< txd_pkg::desc_shift) + txd_pkg::local_addr_t'(txd_pkg::status_byte_offset);
	assign head_next_exp = txd_pkg::ring_idx_t'((int'(exp_head) + 1) % ring_desc);

	tx_desc_ctrl uut (.*);

	always #5 aclk = ~aclk;

	function automatic txd_pkg::desc_flags_t desc_flags_for(input int n);
		txd_pkg::desc_flags_t flags;
		flags.rs = rs_pattern[n];
		// Delay-interrupt on every fourth descriptor
		flags.ide = (n % 4) == 3;
		return flags;
	endfunction

	function automatic bit wants_interrupt(input int n);
		return rs_pattern[n] && (n % 4) != 3;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		errors++;
		$display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
	endtask

	task automatic log_failure(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic set_tail(input txd_pkg::ring_idx_t value);
		@(posedge aclk);
		tdt <= value;
		tdt_set <= 1'b1;
		@(posedge aclk);
		tdt_set <= 1'b0;
	endtask

	task automatic wait_retired(input int count);
		while (retired < count)
			@(posedge aclk);
	endtask

	task automatic check_end_state();
		int exp_wb = 0;
		int exp_txdw = 0;
		for (int n = 0; n < total_desc; n++) begin
			if (rs_pattern[n])
				exp_wb++;
			if (wants_interrupt(n))
				exp_txdw++;
		end
		assert (tdh_fb == second_tail)
			else report_mismatch("tdh_fb", 64'(second_tail), 64'(tdh_fb));
		assert (fetched_total == total_desc)
			else report_mismatch("fetched descriptors", 64'(total_desc), 64'(fetched_total));
		assert (cmd_count == fetched_total)
			else report_mismatch("teng_cmd count", 64'(fetched_total), 64'(cmd_count));
		assert (wb_count == exp_wb)
			else report_mismatch("odma_cmd count", 64'(exp_wb), 64'(wb_count));
		assert (txdw_count == exp_txdw)
			else report_mismatch("txdw_req pulses", 64'(exp_txdw), 64'(txdw_count));
		assert (qe_after_last)
			else log_failure("txqe_req did not pulse after the last retire");
	endtask

	always @(posedge aclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles, %0d errors so far",
				max_cycles, errors);
			$display("Test FAILED");
			$finish;
		end
	end

	// Random stalls on every ready input
	always @(posedge aclk) begin
		idma_ready <= ($urandom % 4) != 0;
		odma_ready <= ($urandom % 3) != 0;
		teng_cmd_ready <= ($urandom % 4) != 0;
	end

	// Host DMA model answers each accepted command with a report pulse a few cycles later
	always @(posedge aclk) begin
		irpt_valid <= 1'b0;
		if (idma_valid && idma_ready) begin
			ird_wait <= 2 + int'($urandom % 4);
		end else if (ird_wait != 0) begin
			ird_wait <= ird_wait - 1;
			if (ird_wait == 1)
				irpt_valid <= 1'b1;
		end
	end

	always @(posedge aclk) begin
		orpt_valid <= 1'b0;
		if (odma_valid && odma_ready) begin
			ord_wait <= 2 + int'($urandom % 4);
		end else if (ord_wait != 0) begin
			ord_wait <= ord_wait - 1;
			if (ord_wait == 1)
				orpt_valid <= 1'b1;
		end
	end

	// Transmit engine model gives one response per launch after a random delay
	always @(posedge aclk) begin
		if (teng_cmd_valid && teng_cmd_ready) begin
			teng_rsp.addr <= teng_cmd;
			teng_rsp.flags <= desc_flags_for(cmd_count);
			eng_wait <= 1 + int'($urandom % 8);
		end else if (eng_wait != 0) begin
			eng_wait <= eng_wait - 1;
			if (eng_wait == 1)
				teng_rsp_valid <= 1'b1;
		end
		if (teng_rsp_valid && teng_rsp_ready)
			teng_rsp_valid <= 1'b0;
	end

	always @(posedge aclk) begin
		if (aresetn) begin
			head_prev <= tdh_fb;
			if (idma_valid && idma_ready) begin
				exp_cur <= txd_pkg::ring_idx_t'((int'(exp_cur) + fetch_desc) % ring_desc);
				fetched_total <= fetched_total + fetch_desc;
			end
			if (teng_cmd_valid && teng_cmd_ready)
				cmd_count <= cmd_count + 1;
			if (odma_valid && odma_ready) begin
				wb_seen <= 1'b1;
				wb_count <= wb_count + 1;
			end
			// Head moves by one per retired descriptor
			if (head_step) begin
				retired <= retired + 1;
				exp_head <= head_next_exp;
				wb_seen <= 1'b0;
			end
			if (txdw_req)
				txdw_count <= txdw_count + 1;
			if (txqe_req && retired + int'(head_step) == total_desc)
				qe_after_last <= 1'b1;
		end
	end

	a_idle: assert property (@(posedge aclk) disable iff (!aresetn)
		!ring_cfg.en |-> idle_outputs == '0 && tdh_fb == '0)
		else report_mismatch("idle outputs and tdh_fb", 64'd0,
			{42'd0, $sampled(idle_outputs), $sampled(tdh_fb)});

	a_fetch_addr: assert property (@(posedge aclk) disable iff (!aresetn)
		idma_valid && idma_ready |-> idma_cmd.host_addr == fetch_addr_exp)
		else report_mismatch("idma_cmd.host_addr", $sampled(fetch_addr_exp),
			$sampled(idma_cmd.host_addr));

	a_fetch_local: assert property (@(posedge aclk) disable iff (!aresetn)
		idma_valid && idma_ready |-> idma_cmd.local_addr == fetch_local_exp)
		else report_mismatch("idma_cmd.local_addr", 64'($sampled(fetch_local_exp)),
			64'($sampled(idma_cmd.local_addr)));

	a_fetch_len: assert property (@(posedge aclk) disable iff (!aresetn)
		idma_valid && idma_ready |-> idma_cmd.len != '0 && idma_cmd.len[3:0] == 4'd0
			&& int'(exp_cur) + fetch_desc <= ring_desc)
		else log_failure($sformatf(
			"fetch of %0d bytes at index %0d is empty or crosses the ring end",
			$sampled(idma_cmd.len), $sampled(exp_cur)));

	a_idma_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		idma_valid && !idma_ready |=> idma_valid && $stable(idma_cmd))
		else log_failure("fetch command changed or dropped while stalled");

	a_odma_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		odma_valid && !odma_ready |=> odma_valid && $stable(odma_cmd))
		else log_failure("write-back command changed or dropped while stalled");

	a_teng_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		teng_cmd_valid && !teng_cmd_ready |=> teng_cmd_valid && $stable(teng_cmd))
		else log_failure("engine command changed or dropped while stalled");

	a_slot_order: assert property (@(posedge aclk) disable iff (!aresetn)
		teng_cmd_valid && teng_cmd_ready |-> teng_cmd == slot_addr_exp)
		else report_mismatch("teng_cmd", 64'($sampled(slot_addr_exp)),
			64'($sampled(teng_cmd)));

	a_cmd_per_desc: assert property (@(posedge aclk) disable iff (!aresetn)
		teng_cmd_valid && teng_cmd_ready |-> cmd_count < fetched_total)
		else log_failure("engine command for a descriptor that was never fetched");

	a_wb_addr: assert property (@(posedge aclk) disable iff (!aresetn)
		odma_valid && odma_ready |-> odma_cmd.host_addr == wb_addr_exp)
		else report_mismatch("odma_cmd.host_addr", $sampled(wb_addr_exp),
			$sampled(odma_cmd.host_addr));

	a_wb_local: assert property (@(posedge aclk) disable iff (!aresetn)
		odma_valid && odma_ready |-> odma_cmd.local_addr == wb_local_exp)
		else report_mismatch("odma_cmd.local_addr", 64'($sampled(wb_local_exp)),
			64'($sampled(odma_cmd.local_addr)));

	a_wb_len: assert property (@(posedge aclk) disable iff (!aresetn)
		odma_valid && odma_ready |-> odma_cmd.len == 16'd1)
		else report_mismatch("odma_cmd.len", 64'd1, 64'($sampled(odma_cmd.len)));

	a_wb_needed: assert property (@(posedge aclk) disable iff (!aresetn)
		odma_valid && odma_ready |-> !wb_seen && rs_pattern[retired])
		else log_failure($sformatf("unexpected write-back for descriptor %0d",
			$sampled(retired)));

	a_retire_wb: assert property (@(posedge aclk) disable iff (!aresetn)
		head_step |-> wb_seen == rs_pattern[retired])
		else log_failure($sformatf("descriptor %0d retired with the wrong write-back",
			$sampled(retired)));

	a_head_step: assert property (@(posedge aclk) disable iff (!aresetn)
		head_step |-> tdh_fb == head_next_exp)
		else report_mismatch("tdh_fb", 64'($sampled(head_next_exp)), 64'($sampled(tdh_fb)));

	a_txdw: assert property (@(posedge aclk) disable iff (!aresetn)
		txdw_req |-> wb_seen && wants_interrupt(retired))
		else log_failure($sformatf("txdw_req raised for descriptor %0d", $sampled(retired)));

	initial begin
		void'($urandom(92786));
		for (int n = 0; n < total_desc; n++)
			rs_pattern[n] = 1'($urandom % 2);
		// Early descriptors cover plain, interrupting and delayed write-back
		rs_pattern[0] = 1'b1;
		rs_pattern[1] = 1'b0;
		rs_pattern[3] = 1'b1;
		repeat (4) @(posedge aclk);
		aresetn <= 1'b1;
		repeat (3) @(posedge aclk);
		ring_cfg <= '{en: 1'b1, base: ring_base, len: ring_len};
		repeat (2) @(posedge aclk);
		set_tail(first_tail);
		wait_retired(int'(first_tail));
		set_tail(second_tail);
		wait_retired(total_desc);
		repeat (8) @(posedge aclk);
		check_end_state();
		$display("Closing: %0d errors, %0d retired, %0d write-backs, %0d interrupts",
			errors, retired, wb_count, txdw_count);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== sim.f ====
logic/txd_pkg.sv
logic/txd_ring_pointers.sv
logic/txd_local_store.sv
logic/txd_host_sequencer.sv
logic/txd_engine_dispatch.sv
logic/tx_desc_ctrl.sv
tests/tb_tx_desc_ctrl.sv

// ==== Makefile ====
TOP = tb_tx_desc_ctrl
OBJ = obj_dir

.PHONY: all lint clean

# Build, run, and pass only if the pass line shows up in the output
all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP) --Mdir $(OBJ)
	@out="$$(./$(OBJ)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sim.f \
		--top-module $(TOP)

clean:
	rm -rf $(OBJ)
